// File: rtl/demod_config.svh
// bus and data path widths, register addresses, mode codes, DAC select codes
`ifndef DEMOD_CONFIG_SVH
`define DEMOD_CONFIG_SVH

// data path widths
`define SAMPLE_W    18
`define FREQ_W      12
`define ALPHA_W     16
`define MODE_W      5
`define DAC_SEL_W   4

// microprocessor bus
`define BUS_W       32
`define ADDR_W      13

// register map
`define ADDR_CTRL       13'h0000
`define ADDR_FLD_ALPHA  13'h0004
`define ADDR_FLD_THRESH 13'h0008
`define ADDR_STATUS     13'h000c

// demodulation modes
`define MODE_OQPSK  5'd1
`define MODE_SOQPSK 5'd3
`define MODE_FM     5'd7

// DAC source selects
`define DAC_I           4'd0
`define DAC_Q           4'd1
`define DAC_FREQ        4'd4
`define DAC_AVGFREQ     4'd10
`define DAC_FREQERROR   4'd11

// absolute average limit, half of full scale
`define FLD_ABS_LIMIT   18'h10000

`endif

// File: rtl/demodPkg.sv
// control register union with its field view
`default_nettype none

`include "demod_config.svh"

package demodPkg;

    // field layout of the control word, msb first
    typedef struct packed {
        logic [11:0]              spareHigh;
        logic [`DAC_SEL_W-1:0]    dac2Select;
        logic [`DAC_SEL_W-1:0]    dac1Select;
        logic [`DAC_SEL_W-1:0]    dac0Select;
        logic [2:0]               spareLow;
        logic [`MODE_W-1:0]       demodMode;
    } demodCtrlFields_t;

    // raw view takes the bus writes, field view feeds the data path
    typedef union packed {
        logic [`BUS_W-1:0]  raw;
        demodCtrlFields_t   f;
    } demodCtrl_u;

endpackage

`default_nettype wire

// File: rtl/demodRegs.sv
// register block: control word, false-lock settings, status readback
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module demodRegs (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire     [`ADDR_W-1:0]       addr,
    input  wire     [`BUS_W-1:0]        din,
    input  wire                         wr0,
    input  wire                         wr1,
    input  wire                         wr2,
    input  wire                         wr3,
    input  wire                         highFreqOffset,
    input  wire                         carrierLock,
    output logic    [`BUS_W-1:0]        dout,
    output demodPkg::demodCtrl_u        ctrl,
    output logic    [`ALPHA_W-1:0]      falseLockAlpha,
    output logic    [`ALPHA_W-1:0]      falseLockThreshold
);

    logic [3:0] lanes;
    logic       ctrlSel;
    logic       alphaSel;
    logic       threshSel;

    assign lanes     = {wr3, wr2, wr1, wr0};
    assign ctrlSel   = (addr == `ADDR_CTRL);
    assign alphaSel  = (addr == `ADDR_FLD_ALPHA);
    assign threshSel = (addr == `ADDR_FLD_THRESH);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl.raw           <= '0;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b] && ctrlSel) begin
                    ctrl.raw[8*b +: 8] <= din[8*b +: 8];
                end
            end
            // settings are 16 bits wide, so only the two low lanes land
            for (int b = 0; b < 2; b++) begin
                if (lanes[b] && alphaSel) begin
                    falseLockAlpha[8*b +: 8] <= din[8*b +: 8];
                end
                if (lanes[b] && threshSel) begin
                    falseLockThreshold[8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        case (addr)
            `ADDR_CTRL:       dout = ctrl.raw;
            `ADDR_FLD_ALPHA:  dout = {{(`BUS_W-`ALPHA_W){1'b0}}, falseLockAlpha};
            `ADDR_FLD_THRESH: dout = {{(`BUS_W-`ALPHA_W){1'b0}}, falseLockThreshold};
            `ADDR_STATUS:     dout = {{(`BUS_W-2){1'b0}}, carrierLock, highFreqOffset};
            default:          dout = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fmDiscriminator.sv
// cross-product FM discriminator with previous sample store
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module fmDiscriminator (
    input  wire                             clk,
    input  wire                             rstN,
    input  wire                             sampleEn,
    input  wire signed  [`SAMPLE_W-1:0]     iIn,
    input  wire signed  [`SAMPLE_W-1:0]     qIn,
    output logic        [`SAMPLE_W-1:0]     fmVideo
);

    logic signed [`SAMPLE_W-1:0]    iPrev;
    logic signed [`SAMPLE_W-1:0]    qPrev;
    logic signed [2*`SAMPLE_W-1:0]  crossNow;
    logic signed [2*`SAMPLE_W-1:0]  crossPrev;
    logic signed [2*`SAMPLE_W-1:0]  crossDiff;

    // iPrev*qNow - qPrev*iNow tracks the phase step between samples
    assign crossNow  = iPrev * qIn;
    assign crossPrev = qPrev * iIn;
    assign crossDiff = crossNow - crossPrev;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iPrev   <= '0;
            qPrev   <= '0;
            fmVideo <= '0;
        end else if (sampleEn) begin
            iPrev   <= iIn;
            qPrev   <= qIn;
            // drop the redundant sign bit and keep the top 18
            fmVideo <= crossDiff[2*`SAMPLE_W-2:`SAMPLE_W-1];
        end
    end

endmodule

`default_nettype wire

// File: rtl/falseLockDetector.sv
// exponential averages of frequency and its magnitude, high offset flag
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module falseLockDetector (
    input  wire                             clk,
    input  wire                             rstN,
    input  wire                             freqEn,
    input  wire signed  [`FREQ_W-1:0]       freq,
    input  wire signed  [`FREQ_W-1:0]       freqError,
    input  wire         [`MODE_W-1:0]       demodMode,
    input  wire                             carrierLock,
    input  wire         [`ALPHA_W-1:0]      falseLockAlpha,
    input  wire         [`ALPHA_W-1:0]      falseLockThreshold,
    output logic signed [`SAMPLE_W-1:0]     averageFreq,
    output logic        [`SAMPLE_W-1:0]     averageAbsFreq,
    output logic                            highFreqOffset
);

    logic signed [`SAMPLE_W:0]      alphaFrac;
    logic signed [`SAMPLE_W:0]      decayFrac;
    logic signed [`SAMPLE_W-1:0]    negFreqSample;
    logic signed [`SAMPLE_W-1:0]    nextFreqSample;
    logic signed [`SAMPLE_W-1:0]    nextAbsSample;
    logic signed [`SAMPLE_W-1:0]    freqSample;
    logic signed [`SAMPLE_W-1:0]    absFreqSample;
    logic signed [2*`SAMPLE_W:0]    alphaProd, decayProd;
    logic signed [2*`SAMPLE_W:0]    absAlphaProd, absDecayProd;
    logic signed [2*`SAMPLE_W:0]    freqSum, absSum;
    logic        [`SAMPLE_W-1:0]    absAverageFreq;

    // alpha and 1-alpha as fractions of 2^17
    assign alphaFrac = {1'b0, falseLockAlpha, 2'b00};
    assign decayFrac = $signed({2'b01, {(`SAMPLE_W-1){1'b0}}}) - alphaFrac;

    assign negFreqSample = {-freq, {(`SAMPLE_W-`FREQ_W){1'b0}}};

    always_comb begin
        case (demodMode)
            `MODE_OQPSK, `MODE_SOQPSK: begin
                nextFreqSample = negFreqSample;
                nextAbsSample  = negFreqSample[`SAMPLE_W-1] ?
                                 {freq, {(`SAMPLE_W-`FREQ_W){1'b0}}} : negFreqSample;
            end
            default: begin
                nextFreqSample = {freqError, {(`SAMPLE_W-`FREQ_W){1'b0}}};
                nextAbsSample  = '0;
            end
        endcase
    end

    // one free-running multiplier stage, settled long before the next freqEn
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            alphaProd    <= '0;
            decayProd    <= '0;
            absAlphaProd <= '0;
            absDecayProd <= '0;
        end else begin
            alphaProd    <= freqSample * alphaFrac;
            decayProd    <= averageFreq * decayFrac;
            absAlphaProd <= absFreqSample * alphaFrac;
            absDecayProd <= $signed(averageAbsFreq) * decayFrac;
        end
    end

    assign freqSum        = alphaProd + decayProd;
    assign absSum         = absAlphaProd + absDecayProd;
    assign absAverageFreq = averageFreq[`SAMPLE_W-1] ? -averageFreq : averageFreq;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            freqSample     <= '0;
            absFreqSample  <= '0;
            averageFreq    <= '0;
            averageAbsFreq <= '0;
            highFreqOffset <= 1'b0;
        end else if (freqEn) begin
            freqSample     <= nextFreqSample;
            absFreqSample  <= nextAbsSample;
            averageFreq    <= freqSum[2*`SAMPLE_W-2:`SAMPLE_W-1];
            averageAbsFreq <= absSum[2*`SAMPLE_W-2:`SAMPLE_W-1];
            if (averageAbsFreq > `FLD_ABS_LIMIT) begin
                highFreqOffset <= 1'b1;
            end else if (absAverageFreq > falseLockThreshold) begin
                // a large mean offset only counts when the loop claims no lock
                highFreqOffset <= !carrierLock;
            end else begin
                highFreqOffset <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/dacOutputMux.sv
// source holding registers and three selectable DAC channels with strobes
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module dacOutputMux (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         sampleEn,
    input  wire                         freqEn,
    input  wire     [`SAMPLE_W-1:0]     iIn,
    input  wire     [`SAMPLE_W-1:0]     qIn,
    input  wire     [`SAMPLE_W-1:0]     fmVideo,
    input  wire     [`FREQ_W-1:0]       freq,
    input  wire     [`FREQ_W-1:0]       freqError,
    input  wire     [`SAMPLE_W-1:0]     averageFreq,
    input  wire     [`SAMPLE_W-1:0]     averageAbsFreq,
    input  demodPkg::demodCtrl_u        ctrl,
    output logic                        dac0Sync,
    output logic                        dac1Sync,
    output logic                        dac2Sync,
    output logic    [`SAMPLE_W-1:0]     dac0Data,
    output logic    [`SAMPLE_W-1:0]     dac1Data,
    output logic    [`SAMPLE_W-1:0]     dac2Data
);

    logic [`SAMPLE_W-1:0] iReg, qReg, fmVideoReg;
    logic [`SAMPLE_W-1:0] freqReg, freqErrorReg, avgFreqReg, avgAbsFreqReg;
    logic                 sampleEnDly, freqEnDly;
    logic                 fmMode;

    assign fmMode = (ctrl.f.demodMode == `MODE_FM);

    // returns {sync, data}; avgSrc differs per channel
    function automatic logic [`SAMPLE_W:0] pickSource(
        input logic [`DAC_SEL_W-1:0] sel,
        input logic [`SAMPLE_W-1:0]  avgSrc
    );
        logic [`SAMPLE_W:0] pick;
        case (sel)
            `DAC_I:         pick = {sampleEnDly, iReg};
            `DAC_Q:         pick = {sampleEnDly, qReg};
            `DAC_FREQ:      pick = fmMode ? {sampleEnDly, fmVideoReg} : {freqEnDly, freqReg};
            `DAC_AVGFREQ:   pick = {freqEnDly, avgSrc};
            `DAC_FREQERROR: pick = {freqEnDly, freqErrorReg};
            default:        pick = {sampleEnDly, iReg};
        endcase
        return pick;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {iReg, qReg, fmVideoReg}                              <= '0;
            {freqReg, freqErrorReg, avgFreqReg, avgAbsFreqReg}    <= '0;
            {sampleEnDly, freqEnDly}                              <= '0;
            {dac0Sync, dac0Data}                                  <= '0;
            {dac1Sync, dac1Data}                                  <= '0;
            {dac2Sync, dac2Data}                                  <= '0;
        end else begin
            sampleEnDly <= sampleEn;
            freqEnDly   <= freqEn;
            // fmVideo lags its strobe by one, so this holds the previous pair
            if (sampleEn) begin
                iReg       <= iIn;
                qReg       <= qIn;
                fmVideoReg <= fmVideo;
            end
            if (freqEn) begin
                freqReg       <= {freq, {(`SAMPLE_W-`FREQ_W){1'b0}}};
                freqErrorReg  <= {freqError, {(`SAMPLE_W-`FREQ_W){1'b0}}};
                avgFreqReg    <= averageFreq;
                avgAbsFreqReg <= averageAbsFreq;
            end
            // channel 1 shows the magnitude average, the others the signed one
            {dac0Sync, dac0Data} <= pickSource(ctrl.f.dac0Select, avgFreqReg);
            {dac1Sync, dac1Data} <= pickSource(ctrl.f.dac1Select, avgAbsFreqReg);
            {dac2Sync, dac2Data} <= pickSource(ctrl.f.dac2Select, avgFreqReg);
        end
    end

endmodule

`default_nettype wire

// File: rtl/demodMonitor.sv
// top level: register block beside FM discriminator, false-lock detector, DAC mux
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module demodMonitor (
    input  wire                     clk,
    input  wire                     rstN,
    input  wire [`ADDR_W-1:0]       addr,
    input  wire [`BUS_W-1:0]        din,
    input  wire                     wr0,
    input  wire                     wr1,
    input  wire                     wr2,
    input  wire                     wr3,
    output wire [`BUS_W-1:0]        dout,
    input  wire                     sampleEn,
    input  wire [`SAMPLE_W-1:0]     iIn,
    input  wire [`SAMPLE_W-1:0]     qIn,
    input  wire                     freqEn,
    input  wire [`FREQ_W-1:0]       freq,
    input  wire [`FREQ_W-1:0]       freqError,
    input  wire                     carrierLock,
    output wire                     highFreqOffset,
    output wire                     dac0Sync,
    output wire                     dac1Sync,
    output wire                     dac2Sync,
    output wire [`SAMPLE_W-1:0]     dac0Data,
    output wire [`SAMPLE_W-1:0]     dac1Data,
    output wire [`SAMPLE_W-1:0]     dac2Data
);

    demodPkg::demodCtrl_u   ctrl;
    wire [`ALPHA_W-1:0]     falseLockAlpha;
    wire [`ALPHA_W-1:0]     falseLockThreshold;
    wire [`SAMPLE_W-1:0]    fmVideo;
    wire [`SAMPLE_W-1:0]    averageFreq;
    wire [`SAMPLE_W-1:0]    averageAbsFreq;

    demodRegs demodRegs_i (
        .clk(clk), .rstN(rstN), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .highFreqOffset(highFreqOffset), .carrierLock(carrierLock),
        .dout(dout), .ctrl(ctrl),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold)
    );

    fmDiscriminator fmDiscriminator_i (
        .clk(clk), .rstN(rstN), .sampleEn(sampleEn),
        .iIn(iIn), .qIn(qIn), .fmVideo(fmVideo)
    );

    falseLockDetector falseLockDetector_i (
        .clk(clk), .rstN(rstN), .freqEn(freqEn),
        .freq(freq), .freqError(freqError),
        .demodMode(ctrl.f.demodMode), .carrierLock(carrierLock),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold),
        .averageFreq(averageFreq), .averageAbsFreq(averageAbsFreq),
        .highFreqOffset(highFreqOffset)
    );

    dacOutputMux dacOutputMux_i (
        .clk(clk), .rstN(rstN), .sampleEn(sampleEn), .freqEn(freqEn),
        .iIn(iIn), .qIn(qIn), .fmVideo(fmVideo),
        .freq(freq), .freqError(freqError),
        .averageFreq(averageFreq), .averageAbsFreq(averageAbsFreq),
        .ctrl(ctrl),
        .dac0Sync(dac0Sync), .dac1Sync(dac1Sync), .dac2Sync(dac2Sync),
        .dac0Data(dac0Data), .dac1Data(dac1Data), .dac2Data(dac2Data)
    );

endmodule

`default_nettype wire

// File: verif/demodMonitor_sva.sv
// concurrent checks on DAC sync pulses and the high offset flag, bound into demodMonitor
`default_nettype none
`timescale 1ns/1ns

module demodMonitor_sva (
    input wire clk,
    input wire rstN,
    input wire freqEn,
    input wire highFreqOffset,
    input wire dac0Sync,
    input wire dac1Sync,
    input wire dac2Sync
);

    // all syncs quiet while reset is held
    syncLowInReset: assert property (@(posedge clk)
        !rstN |-> !(dac0Sync || dac1Sync || dac2Sync))
        else $error("DAC sync output high during reset");

    // single-cycle pulses only
    dac0SyncSingle: assert property (@(posedge clk) disable iff (!rstN)
        dac0Sync |=> !dac0Sync)
        else $error("dac0Sync high on two consecutive cycles");

    dac1SyncSingle: assert property (@(posedge clk) disable iff (!rstN)
        dac1Sync |=> !dac1Sync)
        else $error("dac1Sync high on two consecutive cycles");

    dac2SyncSingle: assert property (@(posedge clk) disable iff (!rstN)
        dac2Sync |=> !dac2Sync)
        else $error("dac2Sync high on two consecutive cycles");

    // flag only moves on a frequency update
    flagFollowsFreqEn: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(highFreqOffset) |-> $past(freqEn))
        else $error("highFreqOffset changed without a preceding freqEn");

endmodule

bind demodMonitor demodMonitor_sva demodMonitorSva_i (
    .clk(clk),
    .rstN(rstN),
    .freqEn(freqEn),
    .highFreqOffset(highFreqOffset),
    .dac0Sync(dac0Sync),
    .dac1Sync(dac1Sync),
    .dac2Sync(dac2Sync)
);

`default_nettype wire

// File: verif/demodMonitorTb.sv
// testbench with clock, reset, bus tasks, sample and frequency stimulus and checks
`default_nettype none
`timescale 1ns/1ns

`include "demod_config.svh"

module demodMonitorTb;

    logic                   clk;
    logic                   rstN;
    logic [`ADDR_W-1:0]     addr;
    logic [`BUS_W-1:0]      din;
    logic                   wr0, wr1, wr2, wr3;
    wire  [`BUS_W-1:0]      dout;
    logic                   sampleEn;
    logic                   freqEn;
    logic                   carrierLock;
    logic [`SAMPLE_W-1:0]   iIn, qIn;
    logic [`FREQ_W-1:0]     freq, freqError;
    wire                    highFreqOffset;
    wire                    dac0Sync, dac1Sync, dac2Sync;
    wire  [`SAMPLE_W-1:0]   dac0Data, dac1Data, dac2Data;

    logic [31:0]            seed = 32'h83a9_45cc;
    int                     checkCount = 0;
    int                     errorCount = 0;
    int                     timeoutCount = 0;

    demodMonitor demodMonitor_i (
        .clk(clk), .rstN(rstN), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .dout(dout),
        .sampleEn(sampleEn), .iIn(iIn), .qIn(qIn),
        .freqEn(freqEn), .freq(freq), .freqError(freqError),
        .carrierLock(carrierLock), .highFreqOffset(highFreqOffset),
        .dac0Sync(dac0Sync), .dac1Sync(dac1Sync), .dac2Sync(dac2Sync),
        .dac0Data(dac0Data), .dac1Data(dac1Data), .dac2Data(dac2Data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // LCG step
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected discriminator output from bits 34:17 of the cross-product difference
    function automatic logic [`SAMPLE_W-1:0] crossValue(
        input logic signed [`SAMPLE_W-1:0] iPrev,
        input logic signed [`SAMPLE_W-1:0] qPrev,
        input logic signed [`SAMPLE_W-1:0] iNow,
        input logic signed [`SAMPLE_W-1:0] qNow
    );
        longint diff;
        diff = longint'(iPrev) * longint'(qNow) - longint'(qPrev) * longint'(iNow);
        return diff[34:17];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("CHECK FAILED at %0t ns: %s expected 0x%h actual 0x%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic writeReg(input logic [`ADDR_W-1:0] a, input logic [`BUS_W-1:0] d,
                            input logic [3:0] lanes);
        @(posedge clk);
        addr <= a;
        din <= d;
        {wr3, wr2, wr1, wr0} <= lanes;
        @(posedge clk);
        {wr3, wr2, wr1, wr0} <= 4'b0;
    endtask

    task automatic readCheck(input logic [`ADDR_W-1:0] a, input logic [`BUS_W-1:0] expected);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        checkValue($sformatf("dout@%h", a), expected, dout);
    endtask

    // idle cycles first keep strobes at least four clocks apart
    task automatic pulseSample(input logic [`SAMPLE_W-1:0] i, input logic [`SAMPLE_W-1:0] q);
        repeat (3) @(posedge clk);
        sampleEn <= 1'b1;
        iIn <= i;
        qIn <= q;
        @(posedge clk);
        sampleEn <= 1'b0;
    endtask

    task automatic pulseFreq(input logic [`FREQ_W-1:0] f, input logic [`FREQ_W-1:0] fe);
        repeat (3) @(posedge clk);
        freqEn <= 1'b1;
        freq <= f;
        freqError <= fe;
        @(posedge clk);
        freqEn <= 1'b0;
    endtask

    // counts clocks from the strobe edge until the channel's sync is seen
    task automatic waitSync(input int ch, output int cycles);
        logic seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < 20) begin
            @(negedge clk);
            cycles++;
            case (ch)
                0:       seen = dac0Sync;
                1:       seen = dac1Sync;
                default: seen = dac2Sync;
            endcase
        end
        if (!seen) begin
            timeoutCount++;
            $display("timeout: no pulse on the sync output of DAC channel %0d", ch);
        end
    endtask

    // runs the frequency stream until the flag reaches the wanted level
    task automatic stepUntilFlag(input logic [`FREQ_W-1:0] f, input logic level);
        int steps;
        int cycles;
        steps = 0;
        @(negedge clk);
        while (highFreqOffset !== level && steps < 60) begin
            pulseFreq(f, '0);
            waitSync(1, cycles);
            checkValue("dac1Data sign", 0, dac1Data[`SAMPLE_W-1]);
            steps++;
        end
        if (highFreqOffset !== level) begin
            timeoutCount++;
            $display("timeout: highFreqOffset never reached %0b", level);
        end
    endtask

    initial begin
        int                     cycles;
        logic [31:0]            r;
        logic [`SAMPLE_W-1:0]   iNow, qNow, iA, qA, iB, qB;
        rstN = 1'b0;
        addr = '0;
        din = '0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        sampleEn = 1'b0;
        freqEn = 1'b0;
        iIn = '0;
        qIn = '0;
        freq = '0;
        freqError = '0;
        carrierLock = 1'b0;
        {iA, qA, iB, qB} = '0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;

        // register readback, partial lanes, unmapped space, status
        writeReg(`ADDR_CTRL, 32'h1234_5687, 4'hf);
        readCheck(`ADDR_CTRL, 32'h1234_5687);
        writeReg(`ADDR_CTRL, 32'haaaa_aaaa, 4'b0100);
        readCheck(`ADDR_CTRL, 32'h12aa_5687);
        writeReg(`ADDR_FLD_ALPHA, 32'hffff_beef, 4'hf);
        readCheck(`ADDR_FLD_ALPHA, 32'h0000_beef);
        writeReg(`ADDR_FLD_THRESH, 32'h0000_1357, 4'h3);
        writeReg(`ADDR_FLD_THRESH, 32'h0000_00cc, 4'h1);
        readCheck(`ADDR_FLD_THRESH, 32'h0000_13cc);
        readCheck(13'h0010, 32'h0);
        readCheck(13'h1ffc, 32'h0);
        @(posedge clk);
        carrierLock <= 1'b1;
        readCheck(`ADDR_STATUS, 32'h2);
        @(posedge clk);
        carrierLock <= 1'b0;
        readCheck(`ADDR_STATUS, 32'h0);

        // FM video on channel 0 shows the pair before the newest sample
        writeReg(`ADDR_CTRL, {12'h0, `DAC_I, `DAC_I, `DAC_FREQ, 3'b0, `MODE_FM}, 4'hf);
        for (int k = 0; k < 24; k++) begin
            r = nextRand();
            iNow = r[31:14];
            r = nextRand();
            qNow = r[31:14];
            pulseSample(iNow, qNow);
            waitSync(0, cycles);
            if (k >= 2) begin
                checkValue("dac0Data fm", crossValue(iA, qA, iB, qB), dac0Data);
            end
            iA = iB;
            qA = qB;
            iB = iNow;
            qB = qNow;
        end

        // routing of I, Q and frequency error
        writeReg(`ADDR_CTRL, {12'h0, `DAC_FREQERROR, `DAC_Q, `DAC_I, 3'b0, `MODE_FM}, 4'hf);
        for (int k = 0; k < 8; k++) begin
            r = nextRand();
            pulseSample(r[17:0], r[31:14]);
            waitSync(0, cycles);
            checkValue("dac0Sync delay", 2, cycles);
            checkValue("dac0Data", r[17:0], dac0Data);
            checkValue("dac1Sync", 1, dac1Sync);
            checkValue("dac1Data", r[31:14], dac1Data);
            pulseFreq(r[11:0], r[27:16]);
            waitSync(2, cycles);
            checkValue("dac2Sync delay", 2, cycles);
            checkValue("dac2Data", {r[27:16], 6'b0}, dac2Data);
        end

        // false lock in OQPSK, alpha one half, small threshold
        writeReg(`ADDR_FLD_ALPHA, 32'h0000_4000, 4'h3);
        writeReg(`ADDR_FLD_THRESH, 32'd100, 4'h3);
        writeReg(`ADDR_CTRL, {12'h0, `DAC_I, `DAC_AVGFREQ, `DAC_I, 3'b0, `MODE_OQPSK}, 4'hf);
        @(posedge clk);
        carrierLock <= 1'b1;
        for (int k = 0; k < 16; k++) begin
            pulseFreq(12'd500, 12'd0);
            waitSync(1, cycles);
            checkValue("dac1Data sign", 0, dac1Data[`SAMPLE_W-1]);
            checkValue("highFreqOffset", 0, highFreqOffset);
        end
        @(posedge clk);
        carrierLock <= 1'b0;
        stepUntilFlag(12'd1000, 1'b1);
        // status bit 0 carries the raised flag
        readCheck(`ADDR_STATUS, 32'h1);
        stepUntilFlag(12'd0, 1'b0);

        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/demodPkg.sv
rtl/demodRegs.sv
rtl/fmDiscriminator.sv
rtl/falseLockDetector.sv
rtl/dacOutputMux.sv
rtl/demodMonitor.sv
verif/demodMonitor_sva.sv
verif/demodMonitorTb.sv

// File: run.sh
#!/bin/sh
# build and run the demodMonitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module demodMonitorTb -f src.f -o simDemod
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simDemod > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
